/* dprx_config.svh */
/*
    DP RX link layer configuration
    Lane count, sync threshold and attribute packet length
*/

`ifndef DPRX_CONFIG_SVH
`define DPRX_CONFIG_SVH

// Link
// Lanes, 1, 2 or 4
`define DPRX_LANES      4

// Consecutive aligned BS beats before lnk_sync
`define DPRX_SYNC_CNT   4

// Main stream attributes
// Payload bytes per attribute packet
`define DPRX_MSA_BYTES  8

`endif

/* dprx_msa_capture.sv */
/*
    DP RX main stream attribute capture
    Collects payload bytes between SS and SE, publishes on a full packet
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module dprx_msa_capture
(
    input wire                  lnk_clk,
    input wire                  arst_n,
    input dprx_pkg::ctl_beat_t  ctl,
    output dprx_pkg::msa_t      msa,        // Last complete packet
    output logic                msa_irq     // One cycle per packet
);

localparam int beat_w = `DPRX_LANES * 8;
localparam int msa_w  = $bits(dprx_pkg::msa_t);
localparam int cnt_w  = $clog2(`DPRX_MSA_BYTES + `DPRX_LANES + 1);

logic [msa_w-1:0] stage;        // Payload shifts in from the top
logic [cnt_w-1:0] byte_cnt;

// Staging shift, lane 0 byte is the oldest
always_ff @(posedge lnk_clk)
begin
    if (ctl.sdp_byte_vld)
        stage <= {ctl.dat, stage[msa_w-1:beat_w]};
end

// Byte count over the run of payload beats, SS beat clears it
always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
        byte_cnt <= '0;
    else if (ctl.sdp_byte_vld)
    begin
        if (byte_cnt <= cnt_w'(`DPRX_MSA_BYTES))   // Saturate on long packets
            byte_cnt <= byte_cnt + cnt_w'(`DPRX_LANES);
    end
    else
        byte_cnt <= '0;
end

always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        msa     <= '0;
        msa_irq <= 1'b0;
    end
    else
    begin
        msa_irq <= 1'b0;
        if (ctl.sdp_end && (byte_cnt == cnt_w'(`DPRX_MSA_BYTES)))
        begin
            msa     <= stage;
            msa_irq <= 1'b1;
        end
    end
end

a_irq_pulse : assert property (@(posedge lnk_clk) disable iff (!arst_n)
    msa_irq |=> !msa_irq)
    else $error("msa_irq longer than one cycle");

endmodule

`default_nettype wire

/* dprx_pkg.sv */
/*
    DP RX link layer types
    Symbol opcodes, stream states, stage beats and the attribute record
*/

`default_nettype none

`include "dprx_config.svh"

package dprx_pkg;

    // K codes
    localparam logic [7:0] k_bs = 8'hbc;    // Blanking start
    localparam logic [7:0] k_be = 8'hfb;    // Blanking end
    localparam logic [7:0] k_ss = 8'h5c;    // Secondary start
    localparam logic [7:0] k_se = 8'hfd;    // Secondary end
    localparam logic [7:0] k_sr = 8'h1c;    // Scrambler reset

    // Symbol opcode
    typedef enum logic [2:0]
    {
        sym_data,               // K flag clear
        sym_bs,
        sym_be,
        sym_ss,
        sym_se,
        sym_sr,
        sym_other               // Unknown K code
    } sym_kind_e;

    // Stream state
    typedef enum logic [1:0]
    {
        st_blank,
        st_vbid,
        st_active,
        st_sdp
    } stream_state_e;

    // One lane, one symbol
    typedef struct packed
    {
        logic       k;
        logic [7:0] dat;
    } lnk_beat_t;

    // Decode stage output
    typedef struct packed
    {
        logic                       vld;
        sym_kind_e                  kind;       // Lane 0 opcode
        logic                       aligned;    // All lanes agree
        logic [`DPRX_LANES*8-1:0]   dat;        // Lane 0 in low byte
    } dec_beat_t;

    // Execute stage output
    typedef struct packed
    {
        logic                       act;            // Active video beat
        logic                       sof;            // First beat of frame
        logic                       line_end;       // Held beat closes the line
        logic                       sdp_byte_vld;   // Attribute payload
        logic                       sdp_end;        // SE seen
        logic [`DPRX_LANES*8-1:0]   dat;
    } ctl_beat_t;

    // Main stream attributes
    // Bytes arrive low first, htotal first, so htotal sits in the low bits
    typedef struct packed
    {
        logic [15:0] vheight;
        logic [15:0] hwidth;
        logic [15:0] vtotal;
        logic [15:0] htotal;
    } msa_t;

endpackage

`default_nettype wire

/* dprx_stream_ctl.sv */
/*
    DP RX stream control
    FSM over blanking, VB-ID, active video and secondary packets
*/

`timescale 1ns/1ps
`default_nettype none

module dprx_stream_ctl
(
    input wire                  lnk_clk,
    input wire                  arst_n,
    input dprx_pkg::dec_beat_t  dec,        // From decoder
    output dprx_pkg::ctl_beat_t ctl         // To capture and video out
);

dprx_pkg::stream_state_e    state;
dprx_pkg::stream_state_e    state_nxt;
logic                       vb_flag;        // Vertical blank from last VB-ID
logic                       vb_flag_nxt;
logic                       sof_pend;       // Next active beat starts a frame
logic                       sof_pend_nxt;
dprx_pkg::ctl_beat_t        ctl_nxt;

always_comb
begin
    state_nxt    = state;
    vb_flag_nxt  = vb_flag;
    sof_pend_nxt = sof_pend;
    ctl_nxt      = '0;
    ctl_nxt.dat  = dec.dat;

    if (dec.vld)
    begin
        case (state)
            dprx_pkg::st_blank :
            begin
                case (dec.kind)
                    dprx_pkg::sym_bs : state_nxt = dprx_pkg::st_vbid;
                    dprx_pkg::sym_be : state_nxt = dprx_pkg::st_active;
                    dprx_pkg::sym_ss : state_nxt = dprx_pkg::st_sdp;
                    default          : state_nxt = dprx_pkg::st_blank;
                endcase
            end

            // Beat after BS carries VB-ID, lane 0 bit 0
            dprx_pkg::st_vbid :
            begin
                vb_flag_nxt = dec.dat[0];
                if (vb_flag && !dec.dat[0])
                    sof_pend_nxt = 1'b1;    // Vertical blank just ended
                state_nxt = dprx_pkg::st_blank;
            end

            dprx_pkg::st_active :
            begin
                if (dec.kind == dprx_pkg::sym_data)
                begin
                    ctl_nxt.act  = 1'b1;
                    ctl_nxt.sof  = sof_pend;
                    sof_pend_nxt = 1'b0;
                end
                else if (dec.kind == dprx_pkg::sym_bs)
                begin
                    ctl_nxt.line_end = 1'b1;    // Next BS closes the line
                    state_nxt        = dprx_pkg::st_vbid;
                end
            end

            dprx_pkg::st_sdp :
            begin
                if (dec.kind == dprx_pkg::sym_data)
                    ctl_nxt.sdp_byte_vld = 1'b1;
                else if (dec.kind == dprx_pkg::sym_se)
                begin
                    ctl_nxt.sdp_end = 1'b1;
                    state_nxt       = dprx_pkg::st_blank;
                end
                else if (dec.kind == dprx_pkg::sym_bs)
                    state_nxt = dprx_pkg::st_vbid;  // Packet cut short
            end

            default : state_nxt = dprx_pkg::st_blank;
        endcase
    end
end

always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        state    <= dprx_pkg::st_blank;
        vb_flag  <= 1'b0;
        sof_pend <= 1'b0;
        ctl      <= '0;
    end
    else
    begin
        state    <= state_nxt;
        vb_flag  <= vb_flag_nxt;
        sof_pend <= sof_pend_nxt;
        ctl      <= ctl_nxt;
    end
end

a_act_sdp_excl : assert property (@(posedge lnk_clk) disable iff (!arst_n)
    !(ctl.act && ctl.sdp_byte_vld))
    else $error("Active and payload beat at once");

endmodule

`default_nettype wire

/* dprx_sym_dec.sv */
/*
    DP RX symbol decoder
    Classifies lane symbols, checks lane alignment, tracks link sync
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module dprx_sym_dec
(
    input wire                                  lnk_clk,
    input wire                                  arst_n,
    input dprx_pkg::lnk_beat_t [`DPRX_LANES-1:0] lnk_in,     // Raw lane symbols
    output dprx_pkg::dec_beat_t                 dec,        // Decoded beat
    output logic                                lnk_sync
);

localparam int cnt_w = $clog2(`DPRX_SYNC_CNT + 1);

dprx_pkg::sym_kind_e        lane_kind [`DPRX_LANES];
logic                       aligned;
logic [`DPRX_LANES*8-1:0]   lane_dat;
logic [cnt_w-1:0]           bs_cnt;         // Consecutive aligned BS beats

// K code to opcode
function automatic dprx_pkg::sym_kind_e kind_of(input dprx_pkg::lnk_beat_t s);
    dprx_pkg::sym_kind_e kind;
    if (!s.k)
        kind = dprx_pkg::sym_data;
    else
    begin
        case (s.dat)
            dprx_pkg::k_bs : kind = dprx_pkg::sym_bs;
            dprx_pkg::k_be : kind = dprx_pkg::sym_be;
            dprx_pkg::k_ss : kind = dprx_pkg::sym_ss;
            dprx_pkg::k_se : kind = dprx_pkg::sym_se;
            dprx_pkg::k_sr : kind = dprx_pkg::sym_sr;
            default        : kind = dprx_pkg::sym_other;
        endcase
    end
    return kind;
endfunction

// Classify lanes and compare against lane 0
always_comb
begin
    aligned = 1'b1;
    for (int i = 0; i < `DPRX_LANES; i++)
    begin
        lane_kind[i]      = kind_of(lnk_in[i]);
        lane_dat[i*8 +: 8] = lnk_in[i].dat;     // Lane 0 lands in low byte
        if (lane_kind[i] != lane_kind[0])
            aligned = 1'b0;
    end
end

// Decode register
always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
        dec <= '0;
    else
    begin
        dec.vld     <= 1'b1;
        dec.kind    <= lane_kind[0];
        dec.aligned <= aligned;
        dec.dat     <= lane_dat;
    end
end

// Link sync, counted on the decoded beat
always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        bs_cnt   <= '0;
        lnk_sync <= 1'b0;
    end
    else if (dec.vld && !dec.aligned)
    begin
        bs_cnt   <= '0;     // Skew restarts the count
        lnk_sync <= 1'b0;
    end
    else if (dec.vld && (dec.kind == dprx_pkg::sym_bs) && (bs_cnt != cnt_w'(`DPRX_SYNC_CNT)))
    begin
        bs_cnt <= bs_cnt + 1'b1;
        if (bs_cnt == cnt_w'(`DPRX_SYNC_CNT - 1))
            lnk_sync <= 1'b1;
    end
end

// Sync must drop right after a misaligned beat
a_sync_drop : assert property (@(posedge lnk_clk) disable iff (!arst_n)
    (dec.vld && !dec.aligned) |=> !lnk_sync)
    else $error("lnk_sync high after misaligned beat");

endmodule

`default_nettype wire

/* dprx_top.sv */
/*
    DP RX link layer top
    Symbol decode, stream control, attribute capture and video output
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module dprx_top
(
    input wire                          lnk_clk,
    input wire                          arst_n,

    // Link
    input wire [`DPRX_LANES*9-1:0]      lnk_dat,    // K flag in bit 8 of each lane
    output wire                         lnk_sync,

    // Video
    input wire                          vid_rdy,
    output wire                         vid_sof,    // Start of frame
    output wire                         vid_eol,    // End of line
    output wire [`DPRX_LANES*8-1:0]     vid_dat,
    output wire                         vid_vld,
    output wire                         vid_ovf,

    // Main stream attributes
    output dprx_pkg::msa_t              msa,
    output wire                         msa_irq
);

dprx_pkg::lnk_beat_t [`DPRX_LANES-1:0]  lnk_in;
dprx_pkg::dec_beat_t                    dec;
dprx_pkg::ctl_beat_t                    ctl;

// Lane slicing
genvar i;
generate
    for (i = 0; i < `DPRX_LANES; i++)
    begin : gen_lane
        assign lnk_in[i].k   = lnk_dat[i*9 + 8];
        assign lnk_in[i].dat = lnk_dat[i*9 +: 8];
    end
endgenerate

dprx_sym_dec i_sym_dec
(
    .lnk_clk    (lnk_clk),
    .arst_n     (arst_n),
    .lnk_in     (lnk_in),
    .dec        (dec),
    .lnk_sync   (lnk_sync)
);

dprx_stream_ctl i_stream_ctl
(
    .lnk_clk    (lnk_clk),
    .arst_n     (arst_n),
    .dec        (dec),
    .ctl        (ctl)
);

dprx_msa_capture i_msa_capture
(
    .lnk_clk    (lnk_clk),
    .arst_n     (arst_n),
    .ctl        (ctl),
    .msa        (msa),
    .msa_irq    (msa_irq)
);

dprx_vid_out i_vid_out
(
    .lnk_clk    (lnk_clk),
    .arst_n     (arst_n),
    .ctl        (ctl),
    .vid_rdy    (vid_rdy),
    .vid_sof    (vid_sof),
    .vid_eol    (vid_eol),
    .vid_dat    (vid_dat),
    .vid_vld    (vid_vld),
    .vid_ovf    (vid_ovf)
);

endmodule

`default_nettype wire

/* dprx_vid_out.sv */
/*
    DP RX video output
    Holds one active beat to find line ends, drives video and overflow
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module dprx_vid_out
(
    input wire                          lnk_clk,
    input wire                          arst_n,
    input dprx_pkg::ctl_beat_t          ctl,
    input wire                          vid_rdy,    // Sink ready level
    output logic                        vid_sof,
    output logic                        vid_eol,
    output logic [`DPRX_LANES*8-1:0]    vid_dat,
    output logic                        vid_vld,
    output logic                        vid_ovf     // Sticky until reset
);

logic                       held_vld;   // Holding an active beat
logic                       held_sof;
logic [`DPRX_LANES*8-1:0]   held_dat;

// Hold stage
always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        held_vld <= 1'b0;
        held_sof <= 1'b0;
    end
    else
    begin
        held_vld <= ctl.act;
        held_sof <= ctl.sof;    // Set upstream only on active beats
    end
end

always_ff @(posedge lnk_clk)
begin
    if (ctl.act)
        held_dat <= ctl.dat;
    if (held_vld)
        vid_dat <= held_dat;    // Raw lane bytes
end

// Emit held beat once the next beat shows whether the line closed
always_ff @(posedge lnk_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        vid_vld <= 1'b0;
        vid_sof <= 1'b0;
        vid_eol <= 1'b0;
        vid_ovf <= 1'b0;
    end
    else
    begin
        vid_vld <= held_vld;
        vid_sof <= held_sof;
        vid_eol <= held_vld && ctl.line_end;    // Empty line gives no eol
        if (vid_vld && !vid_rdy)
            vid_ovf <= 1'b1;    // Refused beat is lost
    end
end

a_flags_vld : assert property (@(posedge lnk_clk) disable iff (!arst_n)
    (vid_sof || vid_eol) |-> vid_vld)
    else $error("vid_sof or vid_eol without vid_vld");

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
    Testbench clock and reset
    40 ns clock, reset low for the first 4 cycles
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
#(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 4
)
(
    output logic clk,
    output logic arst_n
);

initial
begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
end

initial
begin
    arst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2 arst_n = 1'b1;   // Released clear of the edge
end

endmodule

`default_nettype wire

/* tb_dprx.sv */
/*
    DP RX link layer testbench
    Table of link segments driven in order, expected results fed to the checker
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module tb_dprx;

localparam int lanes = `DPRX_LANES;
localparam int n_seg = 24;

typedef enum logic [1:0]
{
    seg_bs,         // BS, VB-ID, idle blanking
    seg_act,        // BE then active beats
    seg_ss,         // SS, payload, SE
    seg_raw         // Idle beats, optionally skewed
} seg_kind_e;

typedef struct packed
{
    seg_kind_e      kind;
    logic [7:0]     beats;      // Control symbols included
    logic           vbid;       // Vertical blank flag
    logic [3:0]     rdy;        // Sink ready per active beat, repeats
    logic           skew;       // Top lane sends BS
    logic [63:0]    msa;        // Payload, low byte first
} seg_t;

seg_t seg_tab [n_seg] = '{
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0},   // Sync builds up
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0},
    '{seg_ss,  4, 0, 4'hf, 0, 64'h0438_0780_0465_0898},
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},   // Vertical blank ends
    '{seg_act, 9, 0, 4'hf, 0, 64'h0},   // Frame start
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_act, 6, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0},
    '{seg_ss,  3, 0, 4'hf, 0, 64'h1111_2222_3333_4444},    // Short packet
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_act, 7, 0, 4'h5, 0, 64'h0},   // Sink refuses every other beat
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_act, 5, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_raw, 2, 0, 4'hf, 1, 64'h0},   // Lane skew
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 0, 4'hf, 0, 64'h0},
    '{seg_ss,  4, 0, 4'hf, 0, 64'h02d0_0500_02ee_0672},
    '{seg_act, 4, 0, 4'hf, 0, 64'h0},
    '{seg_bs,  3, 1, 4'hf, 0, 64'h0}
};

logic                   clk;
logic                   arst_n;
logic [lanes*9-1:0]     lnk_dat;
logic                   vid_rdy;
wire                    lnk_sync;
wire                    vid_sof;
wire                    vid_eol;
wire [lanes*8-1:0]      vid_dat;
wire                    vid_vld;
wire                    vid_ovf;
dprx_pkg::msa_t         msa;
wire                    msa_irq;

integer     seed = 32'h641a;
logic [3:0] rdy_pipe;       // Ready of each driven beat, 4 cycles to vid_vld
int         sync_cnt;
logic       sync_exp;
logic       vb_prev;        // Flag of the last VB-ID
logic       sof_pend;
int         limit = 0;
int         cyc = 0;

tb_clk_gen i_clk (.clk(clk), .arst_n(arst_n));

dprx_top i_dut
(
    .lnk_clk(clk), .arst_n(arst_n), .lnk_dat(lnk_dat), .lnk_sync(lnk_sync),
    .vid_rdy(vid_rdy), .vid_sof(vid_sof), .vid_eol(vid_eol), .vid_dat(vid_dat),
    .vid_vld(vid_vld), .vid_ovf(vid_ovf), .msa(msa), .msa_irq(msa_irq)
);

tb_dprx_check i_check
(
    .clk(clk), .arst_n(arst_n), .lnk_sync(lnk_sync), .vid_rdy(vid_rdy),
    .vid_sof(vid_sof), .vid_eol(vid_eol), .vid_dat(vid_dat), .vid_vld(vid_vld),
    .vid_ovf(vid_ovf), .msa(msa), .msa_irq(msa_irq)
);

function automatic logic [lanes*9-1:0] k_beat(input logic [7:0] code);
    logic [lanes*9-1:0] b;
    for (int l = 0; l < lanes; l++)
        b[l*9 +: 9] = {1'b1, code};
    return b;
endfunction

function automatic logic [lanes*9-1:0] data_beat(input logic [lanes*8-1:0] bytes);
    logic [lanes*9-1:0] b;
    for (int l = 0; l < lanes; l++)
        b[l*9 +: 9] = {1'b0, bytes[l*8 +: 8]};
    return b;
endfunction

function automatic logic [lanes*8-1:0] rand_bytes();
    logic [lanes*8-1:0] r;
    for (int l = 0; l < lanes; l++)
        r[l*8 +: 8] = $random(seed);
    return r;
endfunction

// One beat per cycle, also tracks expected sync
task automatic drive_beat(input logic [lanes*9-1:0] beat, input logic rdy,
                          input logic is_bs, input logic skewed);
    @(posedge clk);
    #2;
    lnk_dat  = beat;
    vid_rdy  = rdy_pipe[3];
    rdy_pipe = {rdy_pipe[2:0], rdy};
    if (skewed)
    begin
        sync_cnt = 0;       // Any skew restarts the run
        sync_exp = 1'b0;
    end
    else if (is_bs && sync_cnt < `DPRX_SYNC_CNT)
    begin
        sync_cnt++;
        if (sync_cnt == `DPRX_SYNC_CNT)
            sync_exp = 1'b1;
    end
    i_check.expect_sync(sync_exp);
endtask

task automatic run_segment(input int n);
    seg_t               s;
    int                 nb;
    logic               next_bs;
    logic [lanes*8-1:0] bytes;
    logic [lanes*9-1:0] beat;
    s       = seg_tab[n];
    nb      = s.beats;
    next_bs = (n + 1 < n_seg) && (seg_tab[n+1].kind == seg_bs);  // Closes the line
    case (s.kind)
        seg_bs :
        begin
            drive_beat(k_beat(8'hbc), 1'b1, 1'b1, 1'b0);
            if (vb_prev && !s.vbid)
                sof_pend = 1'b1;
            vb_prev  = s.vbid;
            bytes    = rand_bytes();
            bytes[0] = s.vbid;      // VB-ID flag in lane 0 bit 0
            drive_beat(data_beat(bytes), 1'b1, 1'b0, 1'b0);
            for (int i = 2; i < nb; i++)
                drive_beat(data_beat(rand_bytes()), 1'b1, 1'b0, 1'b0);
        end
        seg_act :
        begin
            drive_beat(k_beat(8'hfb), 1'b1, 1'b0, 1'b0);
            for (int i = 0; i < nb - 1; i++)
            begin
                bytes = rand_bytes();
                i_check.expect_beat(n, !s.rdy[i % 4], sof_pend, next_bs && (i == nb - 2), bytes);
                sof_pend = 1'b0;
                drive_beat(data_beat(bytes), s.rdy[i % 4], 1'b0, 1'b0);
            end
        end
        seg_ss :
        begin
            drive_beat(k_beat(8'h5c), 1'b1, 1'b0, 1'b0);
            for (int i = 0; i < nb - 2; i++)
                drive_beat(data_beat(s.msa[i*lanes*8 +: lanes*8]), 1'b1, 1'b0, 1'b0);
            drive_beat(k_beat(8'hfd), 1'b1, 1'b0, 1'b0);
            if ((nb - 2) * lanes == `DPRX_MSA_BYTES)
                i_check.expect_msa(n, s.msa);   // Only a full packet publishes
        end
        default :
        begin
            for (int i = 0; i < nb; i++)
            begin
                beat = data_beat(rand_bytes());
                if (s.skew)
                    beat[(lanes-1)*9 +: 9] = {1'b1, 8'hbc};
                drive_beat(beat, 1'b1, 1'b0, s.skew);
            end
        end
    endcase
    i_check.end_entry(n, s.kind.name());
endtask

initial
begin
    lnk_dat  = '0;
    vid_rdy  = 1'b1;
    rdy_pipe = 4'hf;
    sync_cnt = 0;
    sync_exp = 1'b0;
    vb_prev  = 1'b0;
    sof_pend = 1'b0;
    limit    = 50;
    for (int n = 0; n < n_seg; n++)
        limit += 2 * seg_tab[n].beats;
    wait (arst_n === 1'b1);
    for (int n = 0; n < n_seg; n++)
        run_segment(n);
    // Idle blanking until the checker has every result
    while (i_check.busy())
        drive_beat(data_beat(rand_bytes()), 1'b1, 1'b0, 1'b0);
    $display("checks %0d, errors %0d", i_check.chk_cnt, i_check.err_cnt);
    if (i_check.err_cnt == 0)
        $display("TEST PASSED");
    else
        $display("TEST FAILED");
    $finish;
end

// Run limit from the table length
always @(posedge clk)
begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc >= limit)
    begin
        $display("timeout after %0d cycles, results still outstanding", cyc);
        $display("TEST FAILED");
        $finish;
    end
end

endmodule

`default_nettype wire

/* tb_dprx_check.sv */
/*
    DP RX checker
    Compares sync, video beats, overflow and attributes against queued values
*/

`timescale 1ns/1ps
`default_nettype none

`include "dprx_config.svh"

module tb_dprx_check
(
    input wire                          clk,
    input wire                          arst_n,
    input wire                          lnk_sync,
    input wire                          vid_rdy,
    input wire                          vid_sof,
    input wire                          vid_eol,
    input wire [`DPRX_LANES*8-1:0]      vid_dat,
    input wire                          vid_vld,
    input wire                          vid_ovf,
    input dprx_pkg::msa_t               msa,
    input wire                          msa_irq
);

typedef struct packed
{
    logic [7:0]                 idx;    // Table entry
    logic                       drop;   // Sink refuses this one
    logic                       sof;
    logic                       eol;
    logic [`DPRX_LANES*8-1:0]   dat;
} exp_beat_t;

exp_beat_t          beat_q [$];
dprx_pkg::msa_t     msa_q [$];
int                 msa_idx_q [$];
logic               sync_q [$];         // One per driven beat
int                 entry_q [$];
int                 due_q [$];
string              name_q [$];
dprx_pkg::msa_t     msa_last = '0;      // Last published attributes
logic               ovf_exp = 1'b0;
int                 cyc = 0;
int                 err_cnt = 0;
int                 chk_cnt = 0;
int                 err_mark = 0;

task expect_beat(input int idx, input logic drop, input logic sof, input logic eol,
                 input logic [`DPRX_LANES*8-1:0] dat);
    exp_beat_t b;
    b.idx  = idx[7:0];
    b.drop = drop;
    b.sof  = sof;
    b.eol  = eol;
    b.dat  = dat;
    beat_q.push_back(b);
endtask

task expect_msa(input int idx, input dprx_pkg::msa_t m);
    msa_q.push_back(m);
    msa_idx_q.push_back(idx);
endtask

task expect_sync(input logic s);
    sync_q.push_back(s);
endtask

// Results of an entry are all out a few cycles after its last beat
task end_entry(input int idx, input string name);
    entry_q.push_back(idx);
    due_q.push_back(cyc + 7);
    name_q.push_back(name);
endtask

function automatic bit busy();
    return (beat_q.size() + msa_q.size() + entry_q.size()) != 0;
endfunction

task check_val(input string sig, input logic [63:0] exp, input logic [63:0] got);
    chk_cnt++;
    if (exp !== got)
    begin
        err_cnt++;
        $display("error %s: expected %0h, got %0h", sig, exp, got);
    end
endtask

task report_fault(input string msg);
    err_cnt++;
    $display("%s", msg);
endtask

always @(negedge clk)
begin
    exp_beat_t b;
    int        idx;
    string     name;
    if (arst_n)
    begin
        cyc++;
        // Sync lags the driven beat by two cycles
        if (sync_q.size() == 3)
            check_val("lnk_sync", sync_q.pop_front(), lnk_sync);

        check_val("vid_ovf", ovf_exp, vid_ovf);
        if (vid_vld)
        begin
            if (beat_q.size() == 0)
                report_fault("video beat arrived that nothing expected");
            else
            begin
                b = beat_q.pop_front();
                if (b.drop)
                begin
                    if (vid_rdy)
                        report_fault("beat meant to be refused met a ready sink");
                    ovf_exp = 1'b1;     // Lost beat, flag sticks
                end
                else
                begin
                    check_val("vid_dat", b.dat, vid_dat);
                    check_val("vid_sof", b.sof, vid_sof);
                    check_val("vid_eol", b.eol, vid_eol);
                end
            end
        end

        if (msa_irq)
        begin
            if (msa_q.size() == 0)
                report_fault("msa_irq fired without a complete packet");
            else
            begin
                void'(msa_idx_q.pop_front());
                msa_last = msa_q.pop_front();
            end
        end
        check_val("msa", msa_last, msa);    // Holds between packets

        while (entry_q.size() > 0 && due_q[0] <= cyc)
        begin
            idx  = entry_q.pop_front();
            name = name_q.pop_front();
            void'(due_q.pop_front());
            while (msa_idx_q.size() > 0 && msa_idx_q[0] <= idx)
            begin
                report_fault($sformatf("msa_irq never came for entry %0d", idx));
                void'(msa_idx_q.pop_front());
                void'(msa_q.pop_front());
            end
            while (beat_q.size() > 0 && beat_q[0].idx <= idx)
            begin
                report_fault($sformatf("video beat of entry %0d never came out", idx));
                void'(beat_q.pop_front());
            end
            $display("entry %0d %s: %0d errors", idx, name, err_cnt - err_mark);
            err_mark = err_cnt;
        end
    end
end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
dprx_pkg.sv
dprx_sym_dec.sv
dprx_stream_ctl.sv
dprx_msa_capture.sv
dprx_vid_out.sv
dprx_top.sv
tb_clk_gen.sv
tb_dprx_check.sv
tb_dprx.sv
